// File: design/mat_pkg.sv
`default_nettype none

package mat_pkg;

  // unsigned element width
  localparam int DATA_W = 8;

  // array dimension, also the number of lanes per memory word
  localparam int MAT_N = 4;

  // bits needed to pick one row or lane
  localparam int IDX_W = $clog2(MAT_N);

  // one matrix element, sums and products wrap at 2**DATA_W
  typedef logic [DATA_W-1:0] elem_t;

  // one memory word, lane 0 in the low byte
  typedef elem_t [MAT_N-1:0] row_t;

  // accumulator grid, indexed [row][col]
  typedef elem_t [MAT_N-1:0][MAT_N-1:0] grid_t;

endpackage

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // memory geometry
  localparam int ADDR_W   = 7;
  localparam int MEM_SIZE = 128;

  typedef logic [ADDR_W-1:0] addr_t;

  // idle address for A and B, last word
  localparam addr_t PARK_ADDR = addr_t'(MEM_SIZE - 1);

  // sequencer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FEED,
    ST_DRAIN,
    ST_DONE
  } seq_state_e;

  // row 0 final: 2 cycles fetch, MAT_N products, MAT_N-1 hops
  localparam int CAPTURE_BASE = 2 * mat_pkg::MAT_N + 1;
  // last capture, one cycle into the C write regs, one for the write itself
  localparam int DONE_CNT = CAPTURE_BASE + mat_pkg::MAT_N + 2;
  localparam int CNT_W    = $clog2(DONE_CNT + 1);

endpackage

`default_nettype wire

// File: design/mm_array_if.sv
`default_nettype none
`timescale 1ns/1ps

interface mm_array_if;

  import mat_pkg::*;

  // skewed operands entering the left column and top row
  row_t a_edge;
  row_t b_edge;
  // zero all accumulators
  logic acc_clear;
  // live accumulator values
  grid_t c_grid;
  // one-cycle write request for a finished row
  logic capture;
  logic [IDX_W-1:0] capture_row;

  // sequencer side
  modport seq (
    output a_edge,
    output b_edge,
    output acc_clear,
    output capture,
    output capture_row
  );

  // pe grid
  modport array (
    input  a_edge,
    input  b_edge,
    input  acc_clear,
    output c_grid
  );

  // result unit
  modport sink (
    input c_grid,
    input capture,
    input capture_row
  );

endinterface

`default_nettype wire

// File: design/mm_ram.sv
`default_nettype none
`timescale 1ns/1ps

module mm_ram (
  input  logic           clk_mem,
  input  mem_pkg::addr_t addr,
  input  mat_pkg::row_t  wdata,
  input  logic           we,
  output mat_pkg::row_t  rdata
);

  import mat_pkg::*;
  import mem_pkg::*;

  // one row per word
  row_t mem_q [MEM_SIZE];

  // write on the edge
  always_ff @(posedge clk_mem) begin
    if (we) begin
      mem_q[addr] <= wdata;
    end
  end

  // registered read, old contents on a same-address write
  always_ff @(posedge clk_mem) begin
    rdata <= mem_q[addr];
  end

endmodule

`default_nettype wire

// File: design/mm_pe.sv
`default_nettype none
`timescale 1ns/1ps

module mm_pe (
  input  logic           clk_mem,
  input  logic           reset,
  input  logic           acc_clear,
  input  mat_pkg::elem_t in_a,
  input  mat_pkg::elem_t in_b,
  output mat_pkg::elem_t out_a,
  output mat_pkg::elem_t out_b,
  output mat_pkg::elem_t acc
);

  // operand forwarding, a moves right and b moves down
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // multiply-accumulate in one cycle
  // 8-bit context, so product and sum wrap modulo 256
  always_ff @(posedge clk_mem) begin
    if (reset || acc_clear) begin
      acc <= '0;
    end else begin
      acc <= acc + in_a * in_b;
    end
  end

endmodule

`default_nettype wire

// File: design/mm_execute.sv
`default_nettype none
`timescale 1ns/1ps

module mm_execute (
  input logic       clk_mem,
  input logic       reset,
  mm_array_if.array arr
);

  import mat_pkg::*;

  // horizontal links, column MAT_N is the spill past the right edge
  elem_t a_link [MAT_N][MAT_N+1];
  // vertical links, row MAT_N is the spill past the bottom edge
  elem_t b_link [MAT_N+1][MAT_N];
  // collected accumulators
  grid_t acc_grid;

  // lane r of a enters row r, lane r of b enters column r
  for (genvar r = 0; r < MAT_N; r++) begin : g_edge
    assign a_link[r][0] = arr.a_edge[r];
    assign b_link[0][r] = arr.b_edge[r];
  end

  // pe (i,j) holds c[i][j]
  for (genvar i = 0; i < MAT_N; i++) begin : g_row
    for (genvar j = 0; j < MAT_N; j++) begin : g_col
      mm_pe u_pe (
        .clk_mem   (clk_mem),
        .reset     (reset),
        .acc_clear (arr.acc_clear),
        .in_a      (a_link[i][j]),
        .in_b      (b_link[i][j]),
        .out_a     (a_link[i][j+1]),
        .out_b     (b_link[i+1][j]),
        .acc       (acc_grid[i][j])
      );
    end
  end

  assign arr.c_grid = acc_grid;

endmodule

`default_nettype wire

// File: design/mm_decode.sv
`default_nettype none
`timescale 1ns/1ps

module mm_decode (
  input  logic           clk_mem,
  input  logic           reset,
  input  logic           start_mat_mul,
  input  logic           we_a,
  input  logic           we_b,
  input  mem_pkg::addr_t addr_pi,
  output mem_pkg::addr_t a_addr,
  output mem_pkg::addr_t b_addr,
  input  mat_pkg::row_t  a_rd,
  input  mat_pkg::row_t  b_rd,
  output logic           done_mat_mul,
  mm_array_if.seq        arr
);

  import mat_pkg::*;
  import mem_pkg::*;

  seq_state_e       state;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cap_off;
  addr_t            addr_q;
  addr_t            seq_addr;
  logic             fetch_vld;
  row_t             a_q;
  row_t             b_q;

  // host address, one register stage
  // so a host write presents the address one cycle ahead of data and strobe
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      addr_q <= '0;
    end else begin
      addr_q <= addr_pi;
    end
  end

  // sequencer fsm
  // cnt is 0 in the first feed cycle and then counts every cycle
  always_ff @(posedge clk_mem) begin
    if (reset || !start_mat_mul) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          state <= ST_FEED;
        end
        ST_FEED: begin
          cnt <= cnt + 1'b1;
          // last word address going out
          if (cnt == CNT_W'(MAT_N - 1)) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(DONE_CNT - 1)) begin
            state <= ST_DONE;
          end
        end
        default: begin
          // hold until start falls
          state <= ST_DONE;
        end
      endcase
    end
  end

  // words 0..MAT_N-1 during feed, parked otherwise
  assign seq_addr = (state == ST_FEED) ? addr_t'(cnt) : PARK_ADDR;

  // host write owns the port for that memory
  assign a_addr = we_a ? addr_q : seq_addr;
  assign b_addr = we_b ? addr_q : seq_addr;

  // ram output is valid one cycle after a feed address
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      fetch_vld <= 1'b0;
    end else begin
      fetch_vld <= (state == ST_FEED);
    end
  end

  // second stage of the fetch, zero outside the feed window
  // keeps parked-address junk out of the grid
  always_ff @(posedge clk_mem) begin
    if (reset || !fetch_vld) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= a_rd;
      b_q <= b_rd;
    end
  end

  // skew, lane i delayed by i cycles
  for (genvar i = 0; i < MAT_N; i++) begin : g_lane
    elem_t a_pipe [i+1];
    elem_t b_pipe [i+1];

    assign a_pipe[0] = a_q[i];
    assign b_pipe[0] = b_q[i];

    for (genvar s = 1; s <= i; s++) begin : g_stage
      always_ff @(posedge clk_mem) begin
        a_pipe[s] <= a_pipe[s-1];
        b_pipe[s] <= b_pipe[s-1];
      end
    end

    assign arr.a_edge[i] = a_pipe[i];
    assign arr.b_edge[i] = b_pipe[i];
  end

  // accumulators held at zero between runs
  assign arr.acc_clear = (state == ST_IDLE);

  // row r of the grid is final at CAPTURE_BASE + r
  assign cap_off         = cnt - CNT_W'(CAPTURE_BASE);
  assign arr.capture     = (state == ST_DRAIN) && (cnt >= CNT_W'(CAPTURE_BASE))
                           && (cap_off < CNT_W'(MAT_N));
  assign arr.capture_row = cap_off[IDX_W-1:0];

  // level done, dropped as soon as start is released
  assign done_mat_mul = (state == ST_DONE) && start_mat_mul;

endmodule

`default_nettype wire

// File: design/mm_result.sv
`default_nettype none
`timescale 1ns/1ps

module mm_result (
  input  logic           clk_mem,
  input  logic           reset,
  input  logic           rd_en,
  input  mem_pkg::addr_t addr_pi,
  output mem_pkg::addr_t c_addr,
  output mat_pkg::row_t  c_wdata,
  output logic           c_we,
  input  mat_pkg::row_t  c_rd,
  output mat_pkg::row_t  data_from_out_mat,
  mm_array_if.sink       arr
);

  import mem_pkg::*;

  // host read in flight, address stage and ram stage
  logic rd_p1;
  logic rd_p2;

  // c port control
  // capture wins over a host read
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      c_addr <= '0;
      c_we   <= 1'b0;
      rd_p1  <= 1'b0;
      rd_p2  <= 1'b0;
    end else begin
      c_we  <= arr.capture;
      rd_p1 <= rd_en && !arr.capture;
      rd_p2 <= rd_p1;
      if (arr.capture) begin
        // row r goes to address r
        c_addr <= addr_t'(arr.capture_row);
      end else if (rd_en) begin
        c_addr <= addr_pi;
      end
    end
  end

  // row snapshot for the write
  always_ff @(posedge clk_mem) begin
    if (arr.capture) begin
      c_wdata <= arr.c_grid[arr.capture_row];
    end
  end

  // readback register, holds the last row read
  // ready three edges after addr_pi and rd_en
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      data_from_out_mat <= '0;
    end else if (rd_p2) begin
      data_from_out_mat <= c_rd;
    end
  end

endmodule

`default_nettype wire

// File: design/mm_top.sv
`default_nettype none
`timescale 1ns/1ps

module mm_top (
  input  logic           clk_mem,
  input  logic           reset,
  input  logic           start_mat_mul,
  input  logic           we_a,
  input  logic           we_b,
  input  logic           rd_en,
  input  mem_pkg::addr_t addr_pi,
  input  mat_pkg::row_t  data_pi,
  output mat_pkg::row_t  data_from_out_mat,
  output logic           done_mat_mul
);

  import mat_pkg::*;
  import mem_pkg::*;

  // memory ports
  addr_t a_addr;
  addr_t b_addr;
  addr_t c_addr;
  row_t  a_rd;
  row_t  b_rd;
  row_t  c_rd;
  row_t  c_wdata;
  logic  c_we;

  // sequencer to grid to result
  mm_array_if arr_if ();

  // a, word k is column k of A
  mm_ram ram_a (
    .clk_mem (clk_mem),
    .addr    (a_addr),
    .wdata   (data_pi),
    .we      (we_a),
    .rdata   (a_rd)
  );

  // b, word k is row k of B
  mm_ram ram_b (
    .clk_mem (clk_mem),
    .addr    (b_addr),
    .wdata   (data_pi),
    .we      (we_b),
    .rdata   (b_rd)
  );

  // c, word r is row r of the product
  mm_ram ram_c (
    .clk_mem (clk_mem),
    .addr    (c_addr),
    .wdata   (c_wdata),
    .we      (c_we),
    .rdata   (c_rd)
  );

  mm_decode u_decode (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .we_a          (we_a),
    .we_b          (we_b),
    .addr_pi       (addr_pi),
    .a_addr        (a_addr),
    .b_addr        (b_addr),
    .a_rd          (a_rd),
    .b_rd          (b_rd),
    .done_mat_mul  (done_mat_mul),
    .arr           (arr_if)
  );

  mm_execute u_execute (
    .clk_mem (clk_mem),
    .reset   (reset),
    .arr     (arr_if)
  );

  mm_result u_result (
    .clk_mem           (clk_mem),
    .reset             (reset),
    .rd_en             (rd_en),
    .addr_pi           (addr_pi),
    .c_addr            (c_addr),
    .c_wdata           (c_wdata),
    .c_we              (c_we),
    .c_rd              (c_rd),
    .data_from_out_mat (data_from_out_mat),
    .arr               (arr_if)
  );

endmodule

`default_nettype wire

// File: tb/mm_checker.sv
`default_nettype none
`timescale 1ns/1ps

module mm_checker (
  input logic          clk_mem,
  input logic          reset,
  input logic          start_mat_mul,
  input logic          done_mat_mul,
  input mat_pkg::row_t data_from_out_mat
);

  // done only while the host holds start
  a_done_needs_start: assert property (
    @(posedge clk_mem) disable iff (reset)
    !start_mat_mul |-> !done_mat_mul
  ) else $error("done_mat_mul high while start_mat_mul low");

  // once up, done holds as long as start does
  a_done_holds: assert property (
    @(posedge clk_mem) disable iff (reset)
    (done_mat_mul && start_mat_mul) |=> (done_mat_mul || !start_mat_mul)
  ) else $error("done_mat_mul fell while start_mat_mul still high");

  // outputs cleared by reset
  a_reset_zero: assert property (
    @(posedge clk_mem)
    reset |=> (!done_mat_mul && data_from_out_mat == '0)
  ) else $error("done_mat_mul or data_from_out_mat nonzero after reset");

endmodule

// attach to every mm_top
bind mm_top mm_checker u_checker (
  .clk_mem           (clk_mem),
  .reset             (reset),
  .start_mat_mul     (start_mat_mul),
  .done_mat_mul      (done_mat_mul),
  .data_from_out_mat (data_from_out_mat)
);

`default_nettype wire

// File: tb/mm_tb.sv
`default_nettype none
`timescale 1ns/1ps

module mm_tb;

  import mat_pkg::*;
  import mem_pkg::*;

  // dut ports
  logic  clk_mem = 1'b0;
  logic  reset;
  logic  start_mat_mul;
  logic  we_a;
  logic  we_b;
  logic  rd_en;
  addr_t addr_pi;
  row_t  data_pi;
  row_t  data_from_out_mat;
  logic  done_mat_mul;

  // host copies of the operands, [row][col]
  elem_t a_mat [MAT_N][MAT_N];
  elem_t b_mat [MAT_N][MAT_N];

  // expected rows and their C addresses, in read order
  row_t exp_q [$];
  int   row_q [$];
  // read strobe history, one bit per register stage up to data_from_out_mat
  logic [2:0] rd_hist;
  // readbacks compared so far
  int n_cmp;

  // 4 ns period
  always #2 clk_mem = ~clk_mem;

  mm_top dut0 (
    .clk_mem           (clk_mem),
    .reset             (reset),
    .start_mat_mul     (start_mat_mul),
    .we_a              (we_a),
    .we_b              (we_b),
    .rd_en             (rd_en),
    .addr_pi           (addr_pi),
    .data_pi           (data_pi),
    .data_from_out_mat (data_from_out_mat),
    .done_mat_mul      (done_mat_mul)
  );

  // reference model, row i of A times B
  // every element reduced modulo 256
  function automatic row_t mm_expected(input int i);
    row_t res;
    int   sum;
    for (int j = 0; j < MAT_N; j++) begin
      sum = 0;
      for (int k = 0; k < MAT_N; k++) begin
        sum = sum + int'(a_mat[i][k]) * int'(b_mat[k][j]);
      end
      res[j] = elem_t'(sum % 256);
    end
    return res;
  endfunction

  // stop the run with a reason line first
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0d ns: %s, got %h expected %h", $time, what, got, exp));
    end
  endtask

  // host write to A or B
  // address goes out one cycle ahead of strobe and data
  task automatic write_word(input logic sel_b, input addr_t addr, input row_t data);
    addr_pi = addr;
    @(negedge clk_mem);
    data_pi = data;
    if (sel_b) begin
      we_b = 1'b1;
    end else begin
      we_a = 1'b1;
    end
    @(negedge clk_mem);
    we_a = 1'b0;
    we_b = 1'b0;
  endtask

  task automatic fill_random();
    for (int i = 0; i < MAT_N; i++) begin
      for (int j = 0; j < MAT_N; j++) begin
        a_mat[i][j] = elem_t'($urandom());
        b_mat[i][j] = elem_t'($urandom());
      end
    end
  endtask

  task automatic fill_const(input elem_t v);
    for (int i = 0; i < MAT_N; i++) begin
      for (int j = 0; j < MAT_N; j++) begin
        a_mat[i][j] = v;
        b_mat[i][j] = v;
      end
    end
  endtask

  // A word k is column k, B word k is row k
  task automatic load_matrices();
    row_t word;
    for (int k = 0; k < MAT_N; k++) begin
      for (int l = 0; l < MAT_N; l++) begin
        word[l] = a_mat[l][k];
      end
      write_word(1'b0, addr_t'(k), word);
      for (int l = 0; l < MAT_N; l++) begin
        word[l] = b_mat[k][l];
      end
      write_word(1'b1, addr_t'(k), word);
    end
  endtask

  // random words at the parked address and just past the operands
  task automatic write_junk();
    write_word(1'b0, PARK_ADDR, row_t'($urandom()));
    write_word(1'b1, PARK_ADDR, row_t'($urandom()));
    for (int k = 4; k <= 10; k++) begin
      write_word(1'b0, addr_t'(k), row_t'($urandom()));
      write_word(1'b1, addr_t'(k), row_t'($urandom()));
    end
  endtask

  // one multiplication, start held past done then released
  task automatic run_mult();
    int guard;
    start_mat_mul = 1'b1;
    guard = 0;
    while (done_mat_mul !== 1'b1) begin
      @(negedge clk_mem);
      guard++;
      if (guard > 100) begin
        abort_run("timeout: done_mat_mul did not rise after start_mat_mul");
      end
    end
    // done is a level while start stays up
    for (int c = 0; c < 5; c++) begin
      @(negedge clk_mem);
      check_value(32'(done_mat_mul), 32'd1, "done_mat_mul while start held");
    end
    start_mat_mul = 1'b0;
    guard = 0;
    while (done_mat_mul !== 1'b0) begin
      @(negedge clk_mem);
      guard++;
      if (guard > 5) begin
        abort_run("timeout: done_mat_mul stayed high after start_mat_mul dropped");
      end
    end
  endtask

  // queue the expected row, pulse rd_en, wait for the compare
  task automatic read_row(input int r);
    int target;
    int guard;
    target = n_cmp + 1;
    exp_q.push_back(mm_expected(r));
    row_q.push_back(r);
    addr_pi = addr_t'(r);
    rd_en   = 1'b1;
    @(negedge clk_mem);
    rd_en = 1'b0;
    guard = 0;
    while (n_cmp < target) begin
      @(negedge clk_mem);
      guard++;
      if (guard > 8) begin
        abort_run($sformatf("timeout: readback of C row %0d was never compared", r));
      end
    end
  endtask

  task automatic read_all();
    for (int r = 0; r < MAT_N; r++) begin
      read_row(r);
    end
  endtask

  // tracks rd_en through address reg, c address reg and ram
  always @(posedge clk_mem) begin
    if (reset) begin
      rd_hist <= '0;
    end else begin
      rd_hist <= {rd_hist[1:0], rd_en};
    end
  end

  // compare each readback, data stable at the falling edge
  always @(negedge clk_mem) begin : compare_rows
    row_t exp_row;
    int   row_idx;
    if (rd_hist[2]) begin
      if (exp_q.size() == 0) begin
        abort_run("readback arrived with no expected row queued");
      end else begin
        exp_row = exp_q.pop_front();
        row_idx = row_q.pop_front();
        check_value(data_from_out_mat, exp_row, $sformatf("C row %0d", row_idx));
        n_cmp++;
      end
    end
  end

  initial begin
    void'($urandom(32'h3a237b70));
    reset         = 1'b1;
    start_mat_mul = 1'b0;
    we_a          = 1'b0;
    we_b          = 1'b0;
    rd_en         = 1'b0;
    addr_pi       = '0;
    data_pi       = '0;
    n_cmp         = 0;
    repeat (10) @(negedge clk_mem);
    reset = 1'b0;
    @(negedge clk_mem);

    // outputs idle out of reset
    check_value(32'(done_mat_mul), 32'd0, "done_mat_mul after reset");
    check_value(data_from_out_mat, 32'd0, "data_from_out_mat after reset");

    // first random run
    fill_random();
    load_matrices();
    run_mult();
    read_all();

    // fresh operands, accumulators must start from zero again
    fill_random();
    load_matrices();
    run_mult();
    read_all();

    // all 255, every sum wraps
    fill_const(8'hff);
    load_matrices();
    run_mult();
    read_all();

    // junk outside words 0..3 must not reach the grid
    fill_random();
    load_matrices();
    write_junk();
    run_mult();
    read_all();

    if (n_cmp == 4 * MAT_N && exp_q.size() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      abort_run("not every queued readback was compared");
    end
  end

endmodule

`default_nettype wire

// File: build.f
design/mat_pkg.sv
design/mem_pkg.sv
design/mm_array_if.sv
design/mm_ram.sv
design/mm_pe.sv
design/mm_execute.sv
design/mm_decode.sv
design/mm_result.sv
design/mm_top.sv
tb/mm_checker.sv
tb/mm_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with verilator and run, pass only if the testbench reports success
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module mm_tb -f build.f -o mm_sim \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/mm_sim 2>&1)
echo "$out"
echo "$out" | grep -q "^Finished with no errors$" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
